//--- common/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 6;
  localparam int NUM_REGS   = 32;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]           inst_t;
  typedef logic [6:0]            opcode_t;
  typedef logic [2:0]            funct3_t;
  typedef logic [6:0]            funct7_t;

  localparam xlen_t ZERO_WORD = '0;

  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

  typedef struct packed {
    reg_addr_t rs1;
    logic      rs1_ren;
    reg_addr_t rs2;
    logic      rs2_ren;
    reg_addr_t rd;
    logic      rd_wen;
    alu_op_t   alu_op;
    logic      use_imm;
    xlen_t     imm;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    xlen_t     data;
  } wb_req_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    logic      wen;
    xlen_t     data;
    logic      illegal;
  } retire_t;

endpackage

`default_nettype wire

//--- logic/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  wire logic                  inst_valid,
  input  wire rv_exec_pkg::inst_t    inst,
  output rv_exec_pkg::dec_ctrl_t     ctrl
);

  rv_exec_pkg::opcode_t opcode;
  rv_exec_pkg::funct3_t funct3;
  rv_exec_pkg::funct7_t funct7;
  logic [5:0]           funct6;
  rv_exec_pkg::xlen_t   imm_i;
  rv_exec_pkg::xlen_t   imm_u;

  logic                 legal;
  logic                 reads_rs1;
  logic                 reads_rs2;
  logic                 use_imm;
  rv_exec_pkg::alu_op_t op;
  rv_exec_pkg::xlen_t   imm;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign funct6 = inst[31:26];
  assign imm_i  = {{52{inst[31]}}, inst[31:20]};
  assign imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};

  // alt picks SUB / SRA
  function automatic rv_exec_pkg::alu_op_t f3_op(input rv_exec_pkg::funct3_t f3,
                                                 input logic alt);
    case (f3)
      rv_exec_pkg::F3_ADD_SUB: f3_op = alt ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
      rv_exec_pkg::F3_SLL:     f3_op = rv_exec_pkg::ALU_SLL;
      rv_exec_pkg::F3_SLT:     f3_op = rv_exec_pkg::ALU_SLT;
      rv_exec_pkg::F3_SLTU:    f3_op = rv_exec_pkg::ALU_SLTU;
      rv_exec_pkg::F3_XOR:     f3_op = rv_exec_pkg::ALU_XOR;
      rv_exec_pkg::F3_SRL_SRA: f3_op = alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
      rv_exec_pkg::F3_OR:      f3_op = rv_exec_pkg::ALU_OR;
      default:                 f3_op = rv_exec_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    legal     = 1'b0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    use_imm   = 1'b0;
    op        = rv_exec_pkg::ALU_ADD;
    imm       = imm_i;
    case (opcode)
      rv_exec_pkg::OPC_OP: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
        op        = f3_op(funct3, funct7 == rv_exec_pkg::F7_ALT);
        // only SUB and SRA take the alternate funct7
        legal     = (funct7 == rv_exec_pkg::F7_BASE) ||
                    (funct7 == rv_exec_pkg::F7_ALT &&
                     (funct3 == rv_exec_pkg::F3_ADD_SUB ||
                      funct3 == rv_exec_pkg::F3_SRL_SRA));
      end
      rv_exec_pkg::OPC_OP_IMM: begin
        reads_rs1 = 1'b1;
        use_imm   = 1'b1;
        op        = f3_op(funct3, funct3 == rv_exec_pkg::F3_SRL_SRA && inst[30]);
        // RV64 shifts keep a 6-bit shamt, upper bits must be clean
        case (funct3)
          rv_exec_pkg::F3_SLL:     legal = (funct6 == 6'b000000);
          rv_exec_pkg::F3_SRL_SRA: legal = (funct6 == 6'b000000) || (funct6 == 6'b010000);
          default:                 legal = 1'b1;
        endcase
      end
      rv_exec_pkg::OPC_LUI: begin
        use_imm = 1'b1;
        op      = rv_exec_pkg::ALU_PASS_B;
        imm     = imm_u;
        legal   = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    ctrl         = '0;
    ctrl.rs1     = inst[19:15];
    ctrl.rs1_ren = inst_valid && legal && reads_rs1;
    ctrl.rs2     = inst[24:20];
    ctrl.rs2_ren = inst_valid && legal && reads_rs2;
    ctrl.rd      = inst[11:7];
    ctrl.rd_wen  = inst_valid && legal;
    ctrl.alu_op  = op;
    ctrl.use_imm = use_imm;
    ctrl.imm     = imm;
    ctrl.illegal = inst_valid && !legal;
  end

endmodule

`default_nettype wire

//--- regfile/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire                         clk,
  input  wire                         rst,
  input  wire rv_exec_pkg::reg_addr_t rs1,
  input  wire rv_exec_pkg::reg_addr_t rs2,
  input  wire logic                   rs1_ren,
  input  wire logic                   rs2_ren,
  output rv_exec_pkg::xlen_t          rs1_data,
  output rv_exec_pkg::xlen_t          rs2_data,
  input  wire rv_exec_pkg::wb_req_t   wb,
  output rv_exec_pkg::xlen_t          regs_snapshot [rv_exec_pkg::NUM_REGS]
);

  rv_exec_pkg::xlen_t regs [rv_exec_pkg::NUM_REGS];

  // x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
        regs[i] <= rv_exec_pkg::ZERO_WORD;
      end
    end else if (wb.wen && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    if (rst || !rs1_ren) begin
      rs1_data = rv_exec_pkg::ZERO_WORD;
    end else begin
      rs1_data = regs[rs1];
    end
  end

  always_comb begin
    if (rst || !rs2_ren) begin
      rs2_data = rv_exec_pkg::ZERO_WORD;
    end else begin
      rs2_data = regs[rs2];
    end
  end

  // difftest view, pending write shows up in the same cycle
  always_comb begin
    for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
      regs_snapshot[i] = regs[i];
    end
    if (wb.wen && wb.rd != '0) begin
      regs_snapshot[wb.rd] = wb.data;
    end
  end

  // bypass included, x0 must read zero in every cycle
  ap_x0_zero: assert property (
    @(posedge clk) disable iff (rst) regs_snapshot[0] == rv_exec_pkg::ZERO_WORD
  );

endmodule

`default_nettype wire

//--- logic/alu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module alu_writeback (
  input  wire                         clk,
  input  wire                         rst,
  input  wire logic                   inst_valid,
  input  wire rv_exec_pkg::dec_ctrl_t ctrl,
  input  wire rv_exec_pkg::xlen_t     rs1_data,
  input  wire rv_exec_pkg::xlen_t     rs2_data,
  output rv_exec_pkg::wb_req_t        wb,
  output rv_exec_pkg::retire_t        retire
);

  rv_exec_pkg::xlen_t              op_a;
  rv_exec_pkg::xlen_t              op_b;
  rv_exec_pkg::xlen_t              result;
  logic [rv_exec_pkg::SHAMT_W-1:0] shamt;

  assign op_a  = rs1_data;
  assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[rv_exec_pkg::SHAMT_W-1:0];

  always_comb begin
    case (ctrl.alu_op)
      rv_exec_pkg::ALU_ADD:  result = op_a + op_b;
      rv_exec_pkg::ALU_SUB:  result = op_a - op_b;
      rv_exec_pkg::ALU_SLL:  result = op_a << shamt;
      rv_exec_pkg::ALU_SLT:  result = rv_exec_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      rv_exec_pkg::ALU_SLTU: result = rv_exec_pkg::xlen_t'(op_a < op_b);
      rv_exec_pkg::ALU_XOR:  result = op_a ^ op_b;
      rv_exec_pkg::ALU_SRL:  result = op_a >> shamt;
      rv_exec_pkg::ALU_SRA:  result = rv_exec_pkg::xlen_t'($signed(op_a) >>> shamt);
      rv_exec_pkg::ALU_OR:   result = op_a | op_b;
      rv_exec_pkg::ALU_AND:  result = op_a & op_b;
      // LUI
      default:               result = op_b;
    endcase
  end

  // write lands at the edge closing this cycle
  always_comb begin
    wb.wen  = ctrl.rd_wen;
    wb.rd   = ctrl.rd;
    wb.data = result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire <= '0;
    end else begin
      retire.valid   <= inst_valid;
      retire.rd      <= ctrl.rd;
      retire.wen     <= ctrl.rd_wen;
      retire.data    <= result;
      retire.illegal <= ctrl.illegal;
    end
  end

  ap_wen_legal: assert property (
    @(posedge clk) disable iff (rst) retire.wen |-> !retire.illegal
  );

  // idle cycles retire nothing
  ap_idle_quiet: assert property (
    @(posedge clk) disable iff (rst) !retire.valid |-> !retire.wen && !retire.illegal
  );

endmodule

`default_nettype wire

//--- logic/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
  input  wire                      clk,
  input  wire                      rst,
  input  wire logic                inst_valid,
  input  wire rv_exec_pkg::inst_t  inst,
  output rv_exec_pkg::retire_t     retire,
  output rv_exec_pkg::xlen_t       regs_snapshot [rv_exec_pkg::NUM_REGS]
);

  rv_exec_pkg::dec_ctrl_t ctrl;
  rv_exec_pkg::xlen_t     rs1_data;
  rv_exec_pkg::xlen_t     rs2_data;
  rv_exec_pkg::wb_req_t   wb;

  inst_decode u_decode (
    .inst_valid (inst_valid),
    .inst       (inst),
    .ctrl       (ctrl)
  );

  regfile u_regfile (
    .clk           (clk),
    .rst           (rst),
    .rs1           (ctrl.rs1),
    .rs2           (ctrl.rs2),
    .rs1_ren       (ctrl.rs1_ren),
    .rs2_ren       (ctrl.rs2_ren),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .wb            (wb),
    .regs_snapshot (regs_snapshot)
  );

  alu_writeback u_alu (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .wb         (wb),
    .retire     (retire)
  );

endmodule

`default_nettype wire

//--- verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// galois lfsr, right shifting
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    lfsr_next = (s >> 1) ^ 32'hB4BC_D35C;
  end else begin
    lfsr_next = s >> 1;
  end
endfunction

// one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    r = {r[62:0], lfsr_state[0]};
  end
  return r;
endfunction

function automatic rv_exec_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_exec_pkg::OPC_OP};
endfunction

function automatic rv_exec_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, rv_exec_pkg::OPC_OP_IMM};
endfunction

function automatic rv_exec_pkg::inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, rv_exec_pkg::OPC_LUI};
endfunction

// mostly legal forms, a few raw words
function automatic rv_exec_pkg::inst_t gen_inst();
  logic [4:0]  form;
  logic [2:0]  f3;
  logic        alt;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [11:0] imm;
  form = 5'(rand_bits(5));
  f3   = 3'(rand_bits(3));
  alt  = 1'(rand_bits(1));
  rd   = 5'(rand_bits(5));
  rs1  = 5'(rand_bits(5));
  rs2  = 5'(rand_bits(5));
  if (form < 5'd2) begin
    return enc_u(20'(rand_bits(20)), rd);
  end
  if (form > 5'd29) begin
    return 32'(rand_bits(32));
  end
  if (form < 5'd16) begin
    return enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
  end
  imm = 12'(rand_bits(12));
  // shamt in imm[5:0], funct6 above it
  if (f3 == 3'd1) begin
    imm[11:6] = 6'b000000;
  end else if (f3 == 3'd5) begin
    imm[11:6] = alt ? 6'b010000 : 6'b000000;
  end
  return enc_i(imm, rs1, f3, rd);
endfunction

function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [63:0] a, input logic [63:0] b);
  logic [63:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[5:0];
    3'd2: r = {63'b0, ($signed(a) < $signed(b))};
    3'd3: r = {63'b0, (a < b)};
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) begin
        r = $signed(a) >>> b[5:0];
      end else begin
        r = a >> b[5:0];
      end
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// expected retire record, updates the model
function automatic rv_exec_pkg::retire_t exec_ref(input rv_exec_pkg::inst_t w);
  rv_exec_pkg::retire_t r;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] imm_i;
  logic        legal;
  f7    = w[31:25];
  f3    = w[14:12];
  a     = model[w[19:15]];
  b     = model[w[24:20]];
  imm_i = {{52{w[31]}}, w[31:20]};
  r     = '0;
  legal = 1'b0;
  case (w[6:0])
    rv_exec_pkg::OPC_OP: begin
      legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      r.data = alu_ref(f3, f7[5], a, b);
    end
    rv_exec_pkg::OPC_OP_IMM: begin
      if (f3 == 3'd1) begin
        legal = (w[31:26] == 6'b000000);
      end else if (f3 == 3'd5) begin
        legal = (w[31:26] == 6'b000000) || (w[31:26] == 6'b010000);
      end else begin
        legal = 1'b1;
      end
      r.data = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
    end
    rv_exec_pkg::OPC_LUI: begin
      legal  = 1'b1;
      r.data = {{32{w[31]}}, w[31:12], 12'b0};
    end
    default: legal = 1'b0;
  endcase
  r.valid   = 1'b1;
  r.rd      = w[11:7];
  r.wen     = legal;
  r.illegal = !legal;
  if (legal && w[11:7] != 5'd0) begin
    model[w[11:7]] = r.data;
  end
  return r;
endfunction

`endif

//--- verification/tb_rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_top;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 500;
  localparam int NUM_INST     = NUM_RANDOM + 40;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 inst_valid;
  rv_exec_pkg::inst_t   inst;
  rv_exec_pkg::retire_t retire;
  rv_exec_pkg::xlen_t   regs_snapshot [rv_exec_pkg::NUM_REGS];

  logic [63:0]          model [rv_exec_pkg::NUM_REGS] = '{default: '0};
  logic [31:0]          lfsr_state = 32'd88;
  int                   err_count = 0;
  rv_exec_pkg::retire_t exp_prev = '0;

  `include "tb_ref_model.svh"

  rv_exec_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .retire        (retire),
    .regs_snapshot (regs_snapshot)
  );

  always #5 clk = ~clk;

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      err_count++;
      $display("error at %0d ns: %s expected 0x%h got 0x%h", $time, name, exp, act);
    end
  endtask

  task automatic drive_word(input rv_exec_pkg::inst_t w);
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = w;
  endtask

  // junk on inst while idle must not matter
  task automatic drive_idle();
    @(negedge clk);
    inst_valid = 1'b0;
    inst       = 32'(rand_bits(32));
  endtask

  // retire belongs to last cycle's word, snapshot already shows this one's
  always @(posedge clk) begin : compare
    rv_exec_pkg::retire_t exp_now;
    if (!rst) begin
      check_val("retire.valid", 64'(exp_prev.valid), 64'(retire.valid));
      check_val("retire.wen", 64'(exp_prev.wen), 64'(retire.wen));
      check_val("retire.illegal", 64'(exp_prev.illegal), 64'(retire.illegal));
      if (exp_prev.valid) begin
        check_val("retire.rd", 64'(exp_prev.rd), 64'(retire.rd));
      end
      if (exp_prev.wen) begin
        check_val("retire.data", exp_prev.data, retire.data);
      end
      exp_now = '0;
      if (inst_valid) begin
        exp_now = exec_ref(inst);
      end
      for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
        check_val($sformatf("regs_snapshot[%0d]", i), model[i], regs_snapshot[i]);
      end
      exp_prev = exp_now;
    end
  end

  initial begin : watchdog
    #((RESET_CYCLES + NUM_INST * 2 + 50) * 10);
    $display("watchdog timeout, the test sequence did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [2:0] gap;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_val("retire.valid", 64'd0, 64'(retire.valid));

    // constants via lui and addi
    drive_word(enc_u(20'h12345, 5'd1));
    drive_word(enc_i(12'h678, 5'd1, 3'd0, 5'd1));
    drive_word(enc_u(20'hFEDCB, 5'd2));
    drive_word(enc_i(12'h800, 5'd2, 3'd0, 5'd2));
    drive_word(enc_i(12'hFFF, 5'd0, 3'd0, 5'd3));
    // x0 as destination
    drive_word(enc_i(12'h005, 5'd1, 3'd0, 5'd0));
    drive_word(enc_u(20'hABCDE, 5'd0));
    drive_word(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    drive_idle();
    drive_word(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd4));
    drive_word(enc_r(7'h00, 5'd3, 5'd1, 3'd2, 5'd5));
    drive_word(enc_r(7'h00, 5'd3, 5'd1, 3'd3, 5'd6));
    drive_word(enc_i(12'h03F, 5'd3, 3'd1, 5'd7));
    drive_word(enc_i(12'h43F, 5'd7, 3'd5, 5'd8));
    drive_word(enc_i(12'h03F, 5'd7, 3'd5, 5'd9));
    // unsupported encodings
    drive_word(32'h0000_0000);
    drive_word(32'hFFFF_FFFF);
    drive_word(enc_r(7'h20, 5'd2, 5'd1, 3'd4, 5'd10));
    drive_word(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd11));
    drive_word(enc_i(12'h400, 5'd1, 3'd1, 5'd12));
    drive_word({7'h00, 5'd2, 5'd1, 3'd0, 5'd13, 7'h3B});
    drive_idle();
    drive_idle();

    for (int n = 0; n < NUM_RANDOM; n++) begin
      gap = 3'(rand_bits(3));
      if (gap == 3'd0) begin
        drive_idle();
      end
      drive_word(gen_inst());
    end
    drive_idle();
    drive_idle();
    @(negedge clk);

    $display("checks done, error count %0d", err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_exec_slice.f
+incdir+verification
common/rv_exec_pkg.sv
logic/inst_decode.sv
regfile/regfile.sv
logic/alu_writeback.sv
logic/rv_exec_top.sv
verification/tb_rv_exec_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute slice testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f rv_exec_slice.f --top-module tb_rv_exec_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Simulation PASSED$"; then
  exit 0
fi
exit 1
